/* hw/rv_dec_pkg.sv */
package rv_dec_pkg;

    // Integer register and address width of RV64I
    localparam int xlen = 64;

    // Major opcodes that the decode stage recognizes
    localparam logic [6:0] op_load     = 7'b0000011;
    localparam logic [6:0] op_misc_mem = 7'b0001111;
    localparam logic [6:0] op_imm      = 7'b0010011;
    localparam logic [6:0] op_auipc    = 7'b0010111;
    localparam logic [6:0] op_imm_32   = 7'b0011011;
    localparam logic [6:0] op_store    = 7'b0100011;
    localparam logic [6:0] op_reg      = 7'b0110011;
    localparam logic [6:0] op_lui      = 7'b0110111;
    localparam logic [6:0] op_reg_32   = 7'b0111011;
    localparam logic [6:0] op_branch   = 7'b1100011;
    localparam logic [6:0] op_jalr     = 7'b1100111;
    localparam logic [6:0] op_jal      = 7'b1101111;

    // R-format field layout, which also covers the I, U and J formats by slicing
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // S-format layout, where the rd slot carries the low immediate bits
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    // One fetched instruction word seen through either layout
    typedef union packed {
        instr_r_t r;
        instr_s_t s;
    } instr_u;

    // Instruction class handed to the issue stage
    typedef enum logic [2:0] {
        ot_alu,
        ot_branch,
        ot_load,
        ot_store,
        ot_jal,
        ot_jalr,
        ot_fence
    } op_type_e;

    // Source of an ALU operand
    typedef enum logic [1:0] {
        opr_reg,
        opr_imm,
        opr_pc,
        opr_zero
    } operand_sel_e;

    // Control flow kind, conditional for branches and jump for JAL and JALR
    typedef enum logic [1:0] {
        br_none,
        br_cond,
        br_jump
    } br_type_e;

    // Everything the control decoder extracts from one instruction
    typedef struct packed {
        logic [2:0]   alu_op;
        logic         option;
        logic         truncate;
        br_type_e     br_type;
        logic         mem_sign;
        logic [1:0]   mem_width;
        operand_sel_e operand1;
        operand_sel_e operand2;
        op_type_e     op_type;
        logic         legal;
        logic         wb_en;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [4:0]   rd;
        logic         fencei;
    } dec_ctrl_t;

    // Fetch side packet with the branch prediction side-band
    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_u          instr;
        logic            bp;
        logic [xlen-1:0] bt;
    } fetch_pkt_t;

    // Packet presented to the issue stage
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            bp;
        logic [xlen-1:0] bt;
        dec_ctrl_t       ctrl;
        logic [xlen-1:0] imm;
    } issue_pkt_t;

endpackage

/* hw/ctrl_decoder.sv */
`timescale 1ns/1ps

module ctrl_decoder (
    input  rv_dec_pkg::instr_u    instr,
    output rv_dec_pkg::dec_ctrl_t ctrl
);
    import rv_dec_pkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;
    // High when funct7 is the base encoding or the alternate (SUB, SRA) encoding
    logic       f7_ok;

    assign funct7 = instr.r.funct7;
    assign funct3 = instr.r.funct3;
    assign f7_ok  = (funct7 == 7'h00) || (funct7 == 7'h20);

    always_comb begin
        // Register indices come straight from the word whatever the format
        ctrl          = '0;
        ctrl.rs1      = instr.r.rs1;
        ctrl.rs2      = instr.r.rs2;
        ctrl.rd       = instr.r.rd;
        ctrl.br_type  = br_none;
        ctrl.operand1 = opr_reg;
        ctrl.operand2 = opr_reg;
        ctrl.op_type  = ot_alu;

        case (instr.r.opcode)
            op_lui: begin
                // The ALU adds the immediate to zero
                ctrl.operand1 = opr_zero;
                ctrl.operand2 = opr_imm;
                ctrl.legal    = 1'b1;
            end
            op_auipc: begin
                ctrl.operand1 = opr_pc;
                ctrl.operand2 = opr_imm;
                ctrl.legal    = 1'b1;
            end
            op_jal: begin
                ctrl.op_type  = ot_jal;
                ctrl.br_type  = br_jump;
                ctrl.operand1 = opr_pc;
                ctrl.operand2 = opr_imm;
                ctrl.legal    = 1'b1;
            end
            op_jalr: begin
                ctrl.op_type  = ot_jalr;
                ctrl.br_type  = br_jump;
                ctrl.operand2 = opr_imm;
                ctrl.legal    = (funct3 == 3'd0);
            end
            op_branch: begin
                // Encodings 2 and 3 have no branch defined
                ctrl.op_type = ot_branch;
                ctrl.br_type = br_cond;
                ctrl.legal   = (funct3[2:1] != 2'b01);
            end
            op_load: begin
                // funct3 bit 2 marks the zero-extending loads, and LWU is the widest of them
                ctrl.op_type   = ot_load;
                ctrl.operand2  = opr_imm;
                ctrl.mem_sign  = ~funct3[2];
                ctrl.mem_width = funct3[1:0];
                ctrl.legal     = (funct3 != 3'd7);
            end
            op_store: begin
                ctrl.op_type   = ot_store;
                ctrl.operand2  = opr_imm;
                ctrl.mem_width = funct3[1:0];
                ctrl.legal     = ~funct3[2];
            end
            op_imm: begin
                ctrl.alu_op   = funct3;
                ctrl.operand2 = opr_imm;
                // Shift amount is six bits wide here, so only funct7[6:1] is checked
                if (funct3 == 3'd1) begin
                    ctrl.legal = (funct7[6:1] == 6'd0);
                end else if (funct3 == 3'd5) begin
                    ctrl.option = funct7[5];
                    ctrl.legal  = (funct7[6:1] == 6'd0) || (funct7[6:1] == 6'b010000);
                end else begin
                    ctrl.legal = 1'b1;
                end
            end
            op_imm_32: begin
                ctrl.alu_op   = funct3;
                ctrl.truncate = 1'b1;
                ctrl.operand2 = opr_imm;
                // Word shifts take five shamt bits, so bit 25 must be clear
                if (funct3 == 3'd0) begin
                    ctrl.legal = 1'b1;
                end else if (funct3 == 3'd1) begin
                    ctrl.legal = (funct7 == 7'h00);
                end else if (funct3 == 3'd5) begin
                    ctrl.option = funct7[5];
                    ctrl.legal  = f7_ok;
                end
            end
            op_reg: begin
                ctrl.alu_op = funct3;
                ctrl.option = funct7[5];
                // The alternate encoding exists only for SUB and SRA
                ctrl.legal  = (funct7 == 7'h00) ||
                              (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
            end
            op_reg_32: begin
                ctrl.alu_op   = funct3;
                ctrl.option   = funct7[5];
                ctrl.truncate = 1'b1;
                if (funct3 == 3'd0 || funct3 == 3'd5) begin
                    ctrl.legal = f7_ok;
                end else if (funct3 == 3'd1) begin
                    ctrl.legal = (funct7 == 7'h00);
                end
            end
            op_misc_mem: begin
                ctrl.op_type = ot_fence;
                ctrl.fencei  = (funct3 == 3'd1);
                ctrl.legal   = (funct3 == 3'd0) || (funct3 == 3'd1);
            end
            default: begin
                // SYSTEM and unknown opcodes stay illegal
                ctrl.legal = 1'b0;
            end
        endcase

        // Stores, branches and fences produce no register result
        ctrl.wb_en = ctrl.legal && (ctrl.op_type != ot_store) &&
                     (ctrl.op_type != ot_branch) && (ctrl.op_type != ot_fence);
    end

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  rv_dec_pkg::instr_u              instr,
    output logic [rv_dec_pkg::xlen-1:0]     imm
);
    import rv_dec_pkg::*;

    // 32-bit form of the immediate, its bit 31 always equals instruction bit 31
    logic [31:0] raw;

    always_comb begin
        case (instr.r.opcode)
            op_load, op_jalr, op_imm, op_imm_32: begin
                raw = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
            end
            op_store: begin
                raw = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            op_branch: begin
                // Offset is in half-words, bit 7 supplies offset bit 11
                raw = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                       instr.s.imm_lo[4:1], 1'b0};
            end
            op_lui, op_auipc: begin
                raw = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'd0};
            end
            op_jal: begin
                // Bits 19:12 stay in place, bit 20 moves down to offset bit 11
                raw = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
                       instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};
            end
            default: begin
                raw = 32'd0;
            end
        endcase
    end

    assign imm = {{(xlen-32){raw[31]}}, raw};

endmodule

/* hw/dec_stage.sv */
`timescale 1ns/1ps

module dec_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  rv_dec_pkg::fetch_pkt_t          fetch,
    input  logic                            fetch_valid,
    output logic                            fetch_ready,
    input  rv_dec_pkg::dec_ctrl_t           ctrl,
    input  logic [rv_dec_pkg::xlen-1:0]     imm,
    output rv_dec_pkg::issue_pkt_t          issue,
    output logic                            issue_valid,
    input  logic                            issue_ready
);

    // The register can take a new entry if it is empty or its entry leaves this cycle
    assign fetch_ready = !issue_valid || issue_ready;

    // Only the valid bit is under reset and flush control
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (flush) begin
            // Whatever is held or arriving on this edge is thrown away
            issue_valid <= 1'b0;
        end else if (fetch_ready) begin
            issue_valid <= fetch_valid;
        end
    end

    // Payload follows the ready signal so it stays put during a stall
    always_ff @(posedge clk) begin
        if (fetch_ready) begin
            issue.pc   <= fetch.pc;
            issue.bp   <= fetch.bp;
            issue.bt   <= fetch.bt;
            issue.ctrl <= ctrl;
            issue.imm  <= imm;
        end
    end

endmodule

/* hw/dec_top.sv */
`timescale 1ns/1ps

module dec_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  rv_dec_pkg::fetch_pkt_t  fetch,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    output rv_dec_pkg::issue_pkt_t  issue,
    output logic                    issue_valid,
    input  logic                    issue_ready
);
    import rv_dec_pkg::*;

    dec_ctrl_t       ctrl;
    logic [xlen-1:0] imm;

    // Both decoders look at the same fetched word in parallel
    ctrl_decoder u_ctrl_decoder (
        .instr (fetch.instr),
        .ctrl  (ctrl)
    );

    imm_gen u_imm_gen (
        .instr (fetch.instr),
        .imm   (imm)
    );

    dec_stage u_dec_stage (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .ctrl        (ctrl),
        .imm         (imm),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

endmodule

/* verif/dec_props.sv */
`timescale 1ns/1ps

module dec_props (
    input logic                   clk,
    input logic                   rst,
    input logic                   flush,
    input rv_dec_pkg::issue_pkt_t issue,
    input logic                   issue_valid,
    input logic                   issue_ready
);

    // Number of assertion failures so far
    int assert_fails = 0;

    // A stalled packet keeps every bit until the issue stage takes it
    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !issue_ready |=> $stable(issue))
    else begin
        assert_fails++;
        $error("issue packet changed while stalled");
    end

    // Only a flush may take away a packet that is waiting
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !issue_ready && !flush |=> issue_valid)
    else begin
        assert_fails++;
        $error("issue_valid dropped during a stall without a flush");
    end

    a_reset_clears: assert property (@(posedge clk) rst |=> !issue_valid)
    else begin
        assert_fails++;
        $error("issue_valid high after reset");
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (rst) flush |=> !issue_valid)
    else begin
        assert_fails++;
        $error("issue_valid high after flush");
    end

endmodule

/* verif/tb_dec_top.sv */
`timescale 1ns/1ps

module tb_dec_top;
    import rv_dec_pkg::*;

    localparam int n_directed = 40;
    localparam int n_random   = 300;
    localparam int n_stall    = 200;
    localparam int n_flush    = 60;
    // Four cycles per instruction is far above the worst stall rate and 200 more cover reset
    localparam int cycle_limit = 4 * (n_directed + n_random + n_stall + n_flush) + 200;

    logic       clk;
    logic       rst;
    logic       flush;
    fetch_pkt_t fetch;
    logic       fetch_valid;
    logic       fetch_ready;
    issue_pkt_t issue;
    logic       issue_valid;
    logic       issue_ready;

    integer      seed = 32'h6c9;
    logic        stall_mode = 1'b0;
    logic [63:0] next_pc = 64'h0000_0000_8000_0000;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          n_pushed = 0;
    int          n_popped = 0;
    int          n_dropped = 0;
    issue_pkt_t  sb_q[$];

    // Hand-picked encodings whose last eleven entries are reserved or unsupported
    logic [31:0] directed_words [0:n_directed-1] = '{
        32'h123452B7, 32'hFFFFF097, 32'h008000EF, 32'hFF9FF06F, 32'h010100E7, 32'h002081B3,
        32'h402081B3, 32'h4020D1B3, 32'h0020A1B3, 32'hFFF00093, 32'h03F09093, 32'h4210D093,
        32'h8000C093, 32'h8000809B, 32'h01F0909B, 32'h41F0D09B, 32'h002081BB, 32'h402081BB,
        32'h0020D1BB, 32'h00813083, 32'hFFF14083, 32'h00416083, 32'hFE20BC23, 32'h00208023,
        32'h00208863, 32'hFE209EE3, 32'h0020E463, 32'h0FF0000F, 32'h0000100F, 32'h00000073,
        32'h022081B3, 32'h0200909B, 32'h00017083, 32'h0020C023, 32'h0020A063, 32'h010110E7,
        32'h0000200F, 32'h40009093, 32'hFFFFFFFF, 32'h00000000
    };

    // Opcodes for random templates with SYSTEM included to hit the illegal path
    logic [6:0] op_table [0:12] = '{
        op_load, op_store, op_branch, op_jal, op_jalr, op_lui, op_auipc,
        op_imm, op_imm_32, op_reg, op_reg_32, op_misc_mem, 7'h73
    };

    dec_top u_dec_top (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

    bind dec_top dec_props u_dec_props (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

    // Expected packet built from the RV64I field layout and the operand rules
    function automatic issue_pkt_t ref_decode(input fetch_pkt_t f);
        issue_pkt_t  p;
        logic [31:0] w;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        base_ok;
        w  = f.instr;
        f7 = w[31:25];
        f3 = w[14:12];
        p = '0;
        p.pc = f.pc;
        p.bp = f.bp;
        p.bt = f.bt;
        p.ctrl.rs1 = w[19:15];
        p.ctrl.rs2 = w[24:20];
        p.ctrl.rd  = w[11:7];
        p.ctrl.op_type  = ot_alu;
        p.ctrl.br_type  = br_none;
        p.ctrl.operand1 = opr_reg;
        p.ctrl.operand2 = opr_reg;
        // Only SUB, SRA and their word forms use the alternate funct7
        base_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        case (w[6:0])
            op_lui, op_auipc: begin
                // Opcode bit 5 separates LUI from AUIPC
                p.ctrl.operand1 = w[5] ? opr_zero : opr_pc;
                p.ctrl.operand2 = opr_imm;
                p.ctrl.legal    = 1'b1;
                p.imm = {{32{w[31]}}, w[31:12], 12'h000};
            end
            op_jal: begin
                p.ctrl.op_type  = ot_jal;
                p.ctrl.br_type  = br_jump;
                p.ctrl.operand1 = opr_pc;
                p.ctrl.operand2 = opr_imm;
                p.ctrl.legal    = 1'b1;
                p.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            op_jalr: begin
                p.ctrl.op_type  = ot_jalr;
                p.ctrl.br_type  = br_jump;
                p.ctrl.operand2 = opr_imm;
                p.ctrl.legal    = (f3 == 3'd0);
                p.imm = {{52{w[31]}}, w[31:20]};
            end
            op_branch: begin
                p.ctrl.op_type = ot_branch;
                p.ctrl.br_type = br_cond;
                p.ctrl.legal   = (f3 != 3'd2) && (f3 != 3'd3);
                p.imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            op_load: begin
                p.ctrl.op_type   = ot_load;
                p.ctrl.operand2  = opr_imm;
                p.ctrl.mem_sign  = !f3[2];
                p.ctrl.mem_width = f3[1:0];
                p.ctrl.legal     = (f3 != 3'd7);
                p.imm = {{52{w[31]}}, w[31:20]};
            end
            op_store: begin
                p.ctrl.op_type   = ot_store;
                p.ctrl.operand2  = opr_imm;
                p.ctrl.mem_width = f3[1:0];
                p.ctrl.legal     = (f3 < 3'd4);
                p.imm = {{52{w[31]}}, w[31:25], w[11:7]};
            end
            op_imm: begin
                p.ctrl.alu_op   = f3;
                p.ctrl.operand2 = opr_imm;
                p.ctrl.option   = (f3 == 3'd5) ? f7[5] : 1'b0;
                // Six-bit shamt leaves funct7 bit 0 free for the shift amount
                p.ctrl.legal    = (f3 != 3'd1 && f3 != 3'd5) || (f7[6:1] == 6'd0) ||
                                  (f3 == 3'd5 && f7[6:1] == 6'b010000);
                p.imm = {{52{w[31]}}, w[31:20]};
            end
            op_imm_32: begin
                p.ctrl.alu_op   = f3;
                p.ctrl.truncate = 1'b1;
                p.ctrl.operand2 = opr_imm;
                p.ctrl.option   = (f3 == 3'd5) ? f7[5] : 1'b0;
                p.ctrl.legal    = (f3 == 3'd0) || ((f3 == 3'd1 || f3 == 3'd5) && base_ok);
                p.imm = {{52{w[31]}}, w[31:20]};
            end
            op_reg, op_reg_32: begin
                // Opcode bit 3 marks the word forms, which exist for ADD, SLL and the right shifts
                p.ctrl.alu_op   = f3;
                p.ctrl.option   = f7[5];
                p.ctrl.truncate = w[3];
                p.ctrl.legal    = base_ok && (!w[3] || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5);
            end
            op_misc_mem: begin
                p.ctrl.op_type = ot_fence;
                p.ctrl.fencei  = (f3 == 3'd1);
                p.ctrl.legal   = (f3 < 3'd2);
            end
            default: begin
                p.ctrl.legal = 1'b0;
            end
        endcase
        // Every legal opcode writes a register except stores, branches and MISC-MEM
        p.ctrl.wb_en = p.ctrl.legal && (w[6:0] != op_store) && (w[6:0] != op_branch) &&
                       (w[6:0] != op_misc_mem);
        return p;
    endfunction

    task automatic check_equal(input string what, input logic [255:0] actual,
                               input logic [255:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s mismatch, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // Random word on an opcode template that often carries a meaningful funct7
    task automatic rand_word(output logic [31:0] word);
        integer body;
        integer pick;
        body = $random(seed);
        pick = $unsigned($random(seed)) % 14;
        word = body;
        if (pick < 13) word[6:0] = op_table[pick];
        if (body[3]) word[31:25] = body[4] ? 7'h20 : 7'h00;
    endtask

    task automatic build_pkt(input logic [31:0] word, output fetch_pkt_t pkt);
        integer hi;
        integer lo;
        hi = $random(seed);
        lo = $random(seed);
        pkt.pc    = next_pc;
        pkt.instr = word;
        pkt.bp    = hi[31];
        pkt.bt    = {hi, lo};
        next_pc   = next_pc + 64'd4;
    endtask

    // In stall mode the issue stage takes a packet three cycles out of four
    task automatic update_ready();
        integer r;
        r = $random(seed);
        issue_ready = stall_mode ? (r[1:0] != 2'b00) : 1'b1;
    endtask

    // Present one instruction and hold it until the stage accepts it
    task automatic drive_instr(input fetch_pkt_t pkt);
        @(negedge clk);
        fetch       = pkt;
        fetch_valid = 1'b1;
        update_ready();
        @(posedge clk);
        while (!fetch_ready) begin
            @(negedge clk);
            update_ready();
            @(posedge clk);
        end
    endtask

    // Flush while the issue side is stalled so a pending packet is thrown away
    task automatic flush_pulse(input fetch_pkt_t pkt);
        @(negedge clk);
        fetch       = pkt;
        fetch_valid = 1'b1;
        flush       = 1'b1;
        issue_ready = 1'b0;
        @(negedge clk);
        flush       = 1'b0;
        fetch_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // The scoreboard retires on the issue handshake before the flush or a new entry is applied
    initial begin
        issue_pkt_t exp;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (issue_valid && issue_ready) begin
                    if (sb_q.size() == 0) begin
                        errors++;
                        $display("Issue packet at %0t ns with no instruction pending", $time);
                    end else begin
                        exp = sb_q.pop_front();
                        n_popped++;
                        check_equal("pc", issue.pc, exp.pc);
                        check_equal("bp", issue.bp, exp.bp);
                        check_equal("bt", issue.bt, exp.bt);
                        check_equal("ctrl", issue.ctrl, exp.ctrl);
                        check_equal("imm", issue.imm, exp.imm);
                    end
                end
                if (flush) begin
                    n_dropped += sb_q.size();
                    if (fetch_valid && fetch_ready) begin
                        n_pushed++;
                        n_dropped++;
                    end
                    sb_q.delete();
                end else if (fetch_valid && fetch_ready) begin
                    sb_q.push_back(ref_decode(fetch));
                    n_pushed++;
                end
            end
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles before the stimulus completed", cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        fetch_pkt_t  pkt;
        logic [31:0] word;
        rst         = 1'b1;
        flush       = 1'b0;
        fetch       = '0;
        fetch_valid = 1'b0;
        issue_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk) rst = 1'b0;

        // Directed words go back to back with the illegal ones at the end of the table
        for (int i = 0; i < n_directed; i++) begin
            build_pkt(directed_words[i], pkt);
            drive_instr(pkt);
        end
        // Full throughput with the issue side always ready
        for (int i = 0; i < n_random; i++) begin
            rand_word(word);
            build_pkt(word, pkt);
            drive_instr(pkt);
        end
        stall_mode = 1'b1;
        for (int i = 0; i < n_stall; i++) begin
            rand_word(word);
            build_pkt(word, pkt);
            drive_instr(pkt);
        end
        // Stalls continue here while every twelfth instruction turns into a flush
        for (int i = 0; i < n_flush; i++) begin
            rand_word(word);
            build_pkt(word, pkt);
            if (i % 12 == 5) flush_pulse(pkt);
            else drive_instr(pkt);
        end

        @(negedge clk);
        fetch_valid = 1'b0;
        stall_mode  = 1'b0;
        issue_ready = 1'b1;
        while (sb_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);

        // Every accepted instruction that survived a flush came out exactly once
        check_equal("issued count", n_popped, n_pushed - n_dropped);
        errors += u_dec_top.u_dec_props.assert_fails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/rv_dec_pkg.sv
hw/ctrl_decoder.sv
hw/imm_gen.sv
hw/dec_stage.sv
hw/dec_top.sv
verif/dec_props.sv
verif/tb_dec_top.sv

/* Bender.yml */
package:
  name: rv_dec_stage

sources:
  # Shared package, compiled before everything else
  - files:
      - hw/rv_dec_pkg.sv
  # Decode stage RTL
  - files:
      - hw/ctrl_decoder.sv
      - hw/imm_gen.sv
      - hw/dec_stage.sv
      - hw/dec_top.sv
  # Bound properties and testbench
  - target: simulation
    files:
      - verif/dec_props.sv
      - verif/tb_dec_top.sv
